/* alu_axil.f */
design/cpu_alu_pkg.sv
design/alu_op_if.sv
design/alu_shift_unit.sv
design/alu_booth_multiplier.sv
design/alu_divider.sv
design/alu.sv
design/alu_axil_regs.sv
design/alu_axil_top.sv
testbench/alu_axil_sva.sv
testbench/tb_alu_axil_top.sv

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic    clk,
	input logic    rst,
	alu_op_if.alu  op
);

	logic [31:0]              shift_res;
	logic [31:0]              lo_next;
	logic                     legal;
	logic                     is_mul;
	logic                     is_div;
	logic                     mul_fin;
	logic                     div_fin;
	logic                     sc_done;
	logic                     sc_illegal;
	logic                     busy_q;
	cpu_alu_pkg::alu_result_u mul_res;
	cpu_alu_pkg::alu_result_u div_res;
	cpu_alu_pkg::alu_result_u sc_rc;

	assign is_mul = (op.opcode == cpu_alu_pkg::op_mul);
	assign is_div = (op.opcode == cpu_alu_pkg::op_div);

	alu_shift_unit i_shift (
		.ra     (op.ra),
		.amount (op.rb[4:0]),
		.opcode (op.opcode),
		.result (shift_res)
	);

	alu_booth_multiplier i_mul (
		.clk          (clk),
		.rst          (rst),
		.go           (op.start && is_mul),
		.multiplicand (op.ra),
		.multiplier   (op.rb),
		.finished     (mul_fin),
		.product      (mul_res)
	);

	alu_divider i_div (
		.clk      (clk),
		.rst      (rst),
		.go       (op.start && is_div),
		.dividend (op.ra),
		.divisor  (op.rb),
		.finished (div_fin),
		.result   (div_res)
	);

	// ******************************
	// single-cycle decode
	// ******************************
	always_comb begin
		lo_next = '0;
		legal   = 1'b1;
		case (op.opcode)
			cpu_alu_pkg::op_add: lo_next = op.ra + op.rb;
			cpu_alu_pkg::op_sub: lo_next = op.ra - op.rb;
			cpu_alu_pkg::op_and: lo_next = op.ra & op.rb;
			cpu_alu_pkg::op_or:  lo_next = op.ra | op.rb;
			cpu_alu_pkg::op_neg: lo_next = -op.ra;
			cpu_alu_pkg::op_not: lo_next = ~op.ra;
			cpu_alu_pkg::op_shr, cpu_alu_pkg::op_shl, cpu_alu_pkg::op_shra,
			cpu_alu_pkg::op_ror, cpu_alu_pkg::op_rol: lo_next = shift_res;
			cpu_alu_pkg::op_mul, cpu_alu_pkg::op_div: lo_next = '0; // iterative units.
			default: legal = 1'b0; // zero result, flagged.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sc_done    <= 1'b0;
			sc_illegal <= 1'b0;
			busy_q     <= 1'b0;
		end else begin
			sc_done <= op.start && !is_mul && !is_div;
			if (op.start) begin
				sc_illegal <= !legal;
				busy_q     <= 1'b1;
			end else if (op.done) begin
				busy_q <= 1'b0; // low the cycle after done.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (op.start) begin
			sc_rc.prod.hi <= '0;
			sc_rc.prod.lo <= lo_next;
		end
	end

	assign op.busy    = busy_q;
	assign op.done    = sc_done | mul_fin | div_fin;
	assign op.illegal = sc_done & sc_illegal;
	assign op.rc      = mul_fin ? mul_res : (div_fin ? div_res : sc_rc);

endmodule

/* design/alu_axil_regs.sv */
`timescale 1ns/1ps

module alu_axil_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	alu_op_if.regs      op
);

	logic                     wr_hs;
	logic                     rd_hs;
	logic                     ctrl_ok;
	logic [31:0]              ra_q;
	logic [31:0]              rb_q;
	logic [4:0]               opcode_q;
	logic                     start_q;
	logic                     stat_busy;
	logic                     stat_done;
	logic                     stat_illegal;
	cpu_alu_pkg::alu_result_u rc_q;
	logic [31:0]              status_word;
	logic [31:0]              rd_word;
	logic                     rd_err;

	assign wr_hs   = awvalid && wvalid && !bvalid; // aw and w taken together.
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = !rvalid;
	assign rd_hs   = arvalid && !rvalid;
	assign ctrl_ok = wr_hs && (awaddr == cpu_alu_pkg::reg_ctrl) && !stat_busy;

	// ******************************
	// write channel
	// ******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid   <= 1'b0;
			bresp    <= cpu_alu_pkg::resp_okay;
			ra_q     <= '0;
			rb_q     <= '0;
			opcode_q <= '0;
			start_q  <= 1'b0;
		end else begin
			start_q <= ctrl_ok;
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp  <= cpu_alu_pkg::resp_okay;
				case (awaddr)
					cpu_alu_pkg::reg_ra: ra_q <= wdata;
					cpu_alu_pkg::reg_rb: rb_q <= wdata;
					cpu_alu_pkg::reg_ctrl: begin
						if (stat_busy)
							bresp <= cpu_alu_pkg::resp_slverr;
						else
							opcode_q <= wdata[4:0];
					end
					default: bresp <= cpu_alu_pkg::resp_slverr; // read-only or unmapped.
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// status and result capture.
	always_ff @(posedge clk) begin
		if (rst) begin
			stat_busy    <= 1'b0;
			stat_done    <= 1'b0;
			stat_illegal <= 1'b0;
			rc_q         <= '0;
		end else if (ctrl_ok) begin
			stat_busy    <= 1'b1;
			stat_done    <= 1'b0;
			stat_illegal <= 1'b0;
		end else if (op.done) begin
			stat_busy    <= 1'b0;
			stat_done    <= 1'b1;
			stat_illegal <= op.illegal;
			rc_q         <= op.rc;
		end
	end

	// ******************************
	// read channel
	// ******************************
	always_comb begin
		status_word                           = '0;
		status_word[cpu_alu_pkg::st_busy]     = stat_busy;
		status_word[cpu_alu_pkg::st_done]     = stat_done;
		status_word[cpu_alu_pkg::st_illegal]  = stat_illegal;
		rd_word = '0;
		rd_err  = 1'b0;
		case (araddr)
			cpu_alu_pkg::reg_ra:     rd_word = ra_q;
			cpu_alu_pkg::reg_rb:     rd_word = rb_q;
			cpu_alu_pkg::reg_ctrl:   rd_word = {27'd0, opcode_q};
			cpu_alu_pkg::reg_status: rd_word = status_word;
			cpu_alu_pkg::reg_rc_lo:  rd_word = rc_q.prod.lo;
			cpu_alu_pkg::reg_rc_hi:  rd_word = rc_q.prod.hi;
			default:                 rd_err  = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= cpu_alu_pkg::resp_okay;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
			rdata  <= rd_word;
			rresp  <= rd_err ? cpu_alu_pkg::resp_slverr : cpu_alu_pkg::resp_okay;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	assign op.ra     = ra_q;
	assign op.rb     = rb_q;
	assign op.opcode = opcode_q;
	assign op.start  = start_q;

endmodule

/* design/alu_axil_top.sv */
`timescale 1ns/1ps

module alu_axil_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	alu_op_if op_bus ();

	alu_axil_regs i_alu_axil_regs (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.op      (op_bus.regs)
	);

	alu i_alu (
		.clk (clk),
		.rst (rst),
		.op  (op_bus.alu)
	);

endmodule

/* design/alu_booth_multiplier.sv */
`timescale 1ns/1ps

module alu_booth_multiplier (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     go,
	input  logic [31:0]              multiplicand,
	input  logic [31:0]              multiplier,
	output logic                     finished,
	output cpu_alu_pkg::alu_result_u product
);

	logic [32:0] m;      // sign extended multiplicand.
	logic [32:0] acc;    // one guard bit for -m.
	logic [31:0] q;
	logic        q_prev;
	logic [4:0]  count;
	logic        run;
	logic [32:0] sum;

	// booth recoding of the current bit pair.
	always_comb begin
		case ({q[0], q_prev})
			2'b01:   sum = acc + m;
			2'b10:   sum = acc - m;
			default: sum = acc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run      <= 1'b0;
			count    <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (go) begin
				run   <= 1'b1;
				count <= '0;
			end else if (run) begin
				count <= count + 5'd1;
				if (count == 5'd31) begin
					run      <= 1'b0;
					finished <= 1'b1; // after 32nd step.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			m      <= {multiplicand[31], multiplicand};
			acc    <= '0;
			q      <= multiplier;
			q_prev <= 1'b0;
		end else if (run) begin
			acc    <= {sum[32], sum[32:1]}; // arithmetic shift of {acc, q}.
			q      <= {sum[0], q[31:1]};
			q_prev <= q[0];
		end
	end

	always_comb begin
		product.prod.hi = acc[31:0];
		product.prod.lo = q;
	end

endmodule

/* design/alu_divider.sv */
`timescale 1ns/1ps

module alu_divider (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     go,
	input  logic [31:0]              dividend,
	input  logic [31:0]              divisor,
	output logic                     finished,
	output cpu_alu_pkg::alu_result_u result
);

	logic [31:0] dvd;     // original dividend.
	logic [31:0] d;       // divisor magnitude.
	logic [31:0] q;
	logic [32:0] r;       // signed partial remainder.
	logic        neg_q;
	logic        neg_r;
	logic        by_zero;
	logic [4:0]  count;
	logic        run;
	logic [33:0] shifted;
	logic [33:0] trial;
	logic [31:0] rem_mag;
	logic [31:0] quo_s;
	logic [31:0] rem_s;

	assign shifted = {r, q[31]};
	assign trial   = r[32] ? shifted + {2'b00, d} : shifted - {2'b00, d};

	always_ff @(posedge clk) begin
		if (rst) begin
			run      <= 1'b0;
			count    <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (go) begin
				run   <= 1'b1;
				count <= '0;
			end else if (run) begin
				count <= count + 5'd1;
				if (count == 5'd31) begin
					run      <= 1'b0;
					finished <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			dvd     <= dividend;
			d       <= divisor[31] ? -divisor : divisor;
			q       <= dividend[31] ? -dividend : dividend;
			r       <= '0;
			neg_q   <= dividend[31] ^ divisor[31];
			neg_r   <= dividend[31];
			by_zero <= (divisor == '0); // still runs all 32 steps.
		end else if (run) begin
			r <= trial[32:0];
			q <= {q[30:0], ~trial[33]};
		end
	end

	// final restore, then signs back.
	assign rem_mag = r[32] ? r[31:0] + d : r[31:0];
	assign quo_s   = neg_q ? -q : q; // min / -1 wraps to min.
	assign rem_s   = neg_r ? -rem_mag : rem_mag;

	always_comb begin
		result.qr.quo = by_zero ? '1 : quo_s;
		result.qr.rem = by_zero ? dvd : rem_s;
	end

endmodule

/* design/alu_op_if.sv */
`timescale 1ns/1ps

interface alu_op_if;

	// request side.
	logic [31:0]              ra;
	logic [31:0]              rb;
	logic [4:0]               opcode;
	logic                     start; // one cycle pulse.

	// response side.
	logic                     busy;
	logic                     done;  // rc and illegal valid here.
	logic                     illegal;
	cpu_alu_pkg::alu_result_u rc;

	modport regs (
		output ra, rb, opcode, start,
		input  busy, done, illegal, rc
	);

	modport alu (
		input  ra, rb, opcode, start,
		output busy, done, illegal, rc
	);

endinterface

/* design/alu_shift_unit.sv */
`timescale 1ns/1ps

module alu_shift_unit (
	input  logic [31:0] ra,
	input  logic [4:0]  amount,
	input  logic [4:0]  opcode,
	output logic [31:0] result
);

	logic        left;
	logic        rotate;
	logic [31:0] src;
	logic [31:0] upper;
	logic [63:0] wide;
	logic [31:0] right_res;

	function automatic logic [31:0] rev32(input logic [31:0] x);
		logic [31:0] y;
		for (int i = 0; i < 32; i++) begin
			y[i] = x[31 - i];
		end
		return y;
	endfunction

	assign left   = (opcode == cpu_alu_pkg::op_shl) || (opcode == cpu_alu_pkg::op_rol);
	assign rotate = (opcode == cpu_alu_pkg::op_ror) || (opcode == cpu_alu_pkg::op_rol);

	// left shifts go through the right shifter bit-reversed.
	assign src = left ? rev32(ra) : ra;

	always_comb begin
		if (rotate) begin
			upper = src; // wraps back in.
		end else if (opcode == cpu_alu_pkg::op_shra) begin
			upper = {32{ra[31]}}; // sign fill.
		end else begin
			upper = '0;
		end
	end

	assign wide      = {upper, src} >> amount;
	assign right_res = wide[31:0];
	assign result    = left ? rev32(right_res) : right_res;

endmodule

/* design/cpu_alu_pkg.sv */
package cpu_alu_pkg;

	// ******************************
	// opcodes
	// ******************************
	localparam logic [4:0] op_add  = 5'b00011;
	localparam logic [4:0] op_sub  = 5'b00100;
	localparam logic [4:0] op_shr  = 5'b00101;
	localparam logic [4:0] op_shl  = 5'b00110;
	localparam logic [4:0] op_ror  = 5'b00111;
	localparam logic [4:0] op_rol  = 5'b01000;
	localparam logic [4:0] op_and  = 5'b01001;
	localparam logic [4:0] op_or   = 5'b01010;
	localparam logic [4:0] op_mul  = 5'b01110;
	localparam logic [4:0] op_div  = 5'b01111;
	localparam logic [4:0] op_neg  = 5'b10000;
	localparam logic [4:0] op_not  = 5'b10001;
	localparam logic [4:0] op_shra = 5'b10010;

	// ******************************
	// register map
	// ******************************
	localparam logic [11:0] reg_ra     = 12'h000;
	localparam logic [11:0] reg_rb     = 12'h004;
	localparam logic [11:0] reg_ctrl   = 12'h008; // opcode in bits 4:0.
	localparam logic [11:0] reg_status = 12'h00C;
	localparam logic [11:0] reg_rc_lo  = 12'h010;
	localparam logic [11:0] reg_rc_hi  = 12'h014;

	localparam int st_busy    = 0;
	localparam int st_done    = 1; // sticky until next start.
	localparam int st_illegal = 2;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// product view for mul and single-cycle ops, quotient view for div.
	typedef union packed {
		struct packed {
			logic [31:0] hi;
			logic [31:0] lo;
		} prod;
		struct packed {
			logic [31:0] rem;
			logic [31:0] quo;
		} qr;
	} alu_result_u;

endpackage

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_alu_axil_top \
	-f alu_axil.f -o sim_alu_axil \
	&& ./obj_dir/sim_alu_axil | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/alu_axil_sva.sv */
`timescale 1ns/1ps

module alu_axil_sva (
	input logic clk,
	input logic rst,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic start,
	input logic busy,
	input logic done
);

	logic pending; // started, not yet done.
	int   fail_count = 0; // failed assertions.

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (start) begin
			pending <= 1'b1;
		end else if (done) begin
			pending <= 1'b0;
		end
	end

	b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else begin
			$error("start issued while the ALU was busy");
			fail_count++;
		end

	done_after_start: assert property (@(posedge clk) disable iff (rst) done |-> pending)
		else begin
			$error("done without a preceding start");
			fail_count++;
		end

endmodule

bind alu_axil_regs alu_axil_sva i_alu_axil_sva (
	.clk    (clk),
	.rst    (rst),
	.bvalid (bvalid),
	.bready (bready),
	.rvalid (rvalid),
	.rready (rready),
	.start  (op.start),
	.busy   (op.busy),
	.done   (op.done)
);

/* testbench/tb_alu_axil_top.sv */
`timescale 1ns/1ps

module tb_alu_axil_top;

	typedef struct packed {
		logic [4:0]  opc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] lo;
		logic [31:0] hi;
		logic        ill;
	} entry_t;

	logic        clk;
	logic        rst;
	logic [11:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [11:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	entry_t tbl[$];
	integer seed;
	int     stall_max; // longest bready/rready stall.
	int     checks;
	int     errors;

	alu_axil_top i_alu_axil_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic add_entry(input logic [4:0] opc, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] lo, input logic [31:0] hi, input logic ill);
		tbl.push_back('{opc, a, b, lo, hi, ill});
	endtask

	// ******************************
	// axi4-lite host
	// ******************************
	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int stall;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(posedge clk);
		check_val("awready", 32'd1, {31'd0, awready}); // no response pending.
		check_val("wready", 32'd1, {31'd0, wready});
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid && n < 64);
		check_val("awready", 32'd0, {31'd0, awready}); // one cycle only.
		check_val("wready", 32'd0, {31'd0, wready});
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (!bvalid) begin
			$display("timeout: write to offset %h was never accepted", addr);
			errors++;
			resp = bresp;
		end else begin
			stall = $random(seed) & stall_max;
			repeat (stall) @(negedge clk);
			resp   = bresp; // taken at the handshake.
			bready = 1'b1;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (bvalid && n < 64);
			bready = 1'b0;
			if (bvalid) begin
				$display("timeout: write response for offset %h never completed", addr);
				errors++;
			end
		end
	endtask

	task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int stall;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge clk);
		check_val("arready", 32'd1, {31'd0, arready}); // no read data pending.
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rvalid && n < 64);
		check_val("arready", 32'd0, {31'd0, arready});
		arvalid = 1'b0;
		if (!rvalid) begin
			$display("timeout: read of offset %h was never accepted", addr);
			errors++;
			data = rdata;
			resp = rresp;
		end else begin
			stall = $random(seed) & stall_max;
			repeat (stall) @(negedge clk);
			data   = rdata; // taken at the handshake.
			resp   = rresp;
			rready = 1'b1;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (rvalid && n < 64);
			rready = 1'b0;
			if (rvalid) begin
				$display("timeout: read data for offset %h never completed", addr);
				errors++;
			end
		end
	endtask

	task automatic wait_done(output logic [31:0] st);
		logic [1:0] resp;
		int         polls;
		polls = 0;
		do begin
			axil_read(cpu_alu_pkg::reg_status, st, resp);
			polls++;
		end while (!st[cpu_alu_pkg::st_done] && polls < 200);
		if (!st[cpu_alu_pkg::st_done]) begin
			$display("timeout: status never showed done after %0d polls", polls);
			errors++;
		end
	endtask

	task automatic run_entry(input entry_t e);
		logic [31:0] st;
		logic [31:0] d;
		logic [1:0]  resp;
		axil_write(cpu_alu_pkg::reg_ra, e.a, resp);
		axil_write(cpu_alu_pkg::reg_rb, e.b, resp);
		axil_write(cpu_alu_pkg::reg_ctrl, {27'd0, e.opc}, resp);
		check_val("bresp", {30'd0, cpu_alu_pkg::resp_okay}, {30'd0, resp});
		wait_done(st);
		check_val("status.illegal", {31'd0, e.ill}, {31'd0, st[cpu_alu_pkg::st_illegal]});
		axil_read(cpu_alu_pkg::reg_rc_lo, d, resp);
		check_val("rc_lo", e.lo, d);
		axil_read(cpu_alu_pkg::reg_rc_hi, d, resp);
		check_val("rc_hi", e.hi, d);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] d;
		logic [1:0]  resp;
		longint      p;
		int          r;
		int          q;
		int          rm;
		int          sva_fails;
		seed = 355;
		stall_max = 0;
		checks = 0;
		errors = 0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// ******************************
		// operation table
		// ******************************
		add_entry(cpu_alu_pkg::op_add, 32'h7fffffff, 32'h00000001, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_add, 32'hffffffff, 32'h00000001, 32'h00000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_sub, 32'h00000005, 32'h00000007, 32'hfffffffe, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_and, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_or, 32'hf0f00000, 32'h0000000f, 32'hf0f0000f, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_neg, 32'h00000001, 32'h0, 32'hffffffff, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_neg, 32'h80000000, 32'h0, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_not, 32'h0f0f0f0f, 32'h0, 32'hf0f0f0f0, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shr, 32'h80000001, 32'd0, 32'h80000001, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shr, 32'h80000001, 32'd1, 32'h40000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shr, 32'h80000001, 32'd31, 32'h00000001, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shl, 32'h80000001, 32'd0, 32'h80000001, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shl, 32'h80000001, 32'd1, 32'h00000002, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shl, 32'h00000003, 32'd31, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shra, 32'h80000000, 32'd0, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shra, 32'h80000000, 32'd1, 32'hc0000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_shra, 32'h80000000, 32'd31, 32'hffffffff, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_ror, 32'h12345678, 32'd32, 32'h12345678, 32'h0, 1'b0); // rb[4:0] only.
		add_entry(cpu_alu_pkg::op_ror, 32'h00000001, 32'd1, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_ror, 32'h80000001, 32'd31, 32'h00000003, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_rol, 32'h12345678, 32'd0, 32'h12345678, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_rol, 32'h80000000, 32'd1, 32'h00000001, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_rol, 32'h00000001, 32'd31, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_mul, 32'h00000003, 32'hfffffffe, 32'hfffffffa, 32'hffffffff, 1'b0);
		add_entry(cpu_alu_pkg::op_mul, 32'hfffffff9, 32'hfffffffd, 32'h00000015, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_mul, 32'h80000000, 32'h80000000, 32'h0, 32'h40000000, 1'b0);
		add_entry(cpu_alu_pkg::op_mul, 32'h80000000, 32'hffffffff, 32'h80000000, 32'h0, 1'b0);
		add_entry(cpu_alu_pkg::op_mul, 32'h7fffffff, 32'h7fffffff, 32'h00000001, 32'h3fffffff, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'd7, 32'd2, 32'd3, 32'd1, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'hfffffff9, 32'd2, 32'hfffffffd, 32'hffffffff, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'd7, 32'hfffffffe, 32'hfffffffd, 32'd1, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'hfffffff9, 32'hfffffffe, 32'd3, 32'hffffffff, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'h00001234, 32'd0, 32'hffffffff, 32'h00001234, 1'b0);
		add_entry(cpu_alu_pkg::op_div, 32'h80000000, 32'hffffffff, 32'h80000000, 32'h0, 1'b0);
		add_entry(5'd0, 32'd5, 32'd6, 32'h0, 32'h0, 1'b1);
		add_entry(cpu_alu_pkg::op_add, 32'd1, 32'd1, 32'd2, 32'h0, 1'b0); // clears illegal.

		for (int i = 0; i < 8; i++) begin
			a = $random(seed);
			b = $random(seed);
			p = longint'($signed(a)) * longint'($signed(b));
			add_entry(cpu_alu_pkg::op_mul, a, b, p[31:0], p[63:32], 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			a = $random(seed);
			r = $random(seed);
			b = r >>> 20; // small signed divisor.
			if (b == 32'd0) b = 32'd5;
			q = $signed(a) / $signed(b);
			rm = $signed(a) % $signed(b);
			add_entry(cpu_alu_pkg::op_div, a, b, q, rm, 1'b0);
		end

		foreach (tbl[i]) run_entry(tbl[i]);
		stall_max = 7; // same table under back-pressure.
		foreach (tbl[i]) run_entry(tbl[i]);
		stall_max = 0;

		// ******************************
		// protocol errors
		// ******************************
		axil_write(cpu_alu_pkg::reg_ra, 32'hfffffff9, resp);
		axil_write(cpu_alu_pkg::reg_rb, 32'd1000, resp);
		axil_write(cpu_alu_pkg::reg_ctrl, {27'd0, cpu_alu_pkg::op_mul}, resp);
		axil_write(cpu_alu_pkg::reg_ctrl, {27'd0, cpu_alu_pkg::op_add}, resp); // mid multiply.
		check_val("bresp", {30'd0, cpu_alu_pkg::resp_slverr}, {30'd0, resp});
		wait_done(d);
		axil_read(cpu_alu_pkg::reg_rc_lo, d, resp);
		check_val("rc_lo", 32'hffffe4a8, d);
		axil_read(cpu_alu_pkg::reg_rc_hi, d, resp);
		check_val("rc_hi", 32'hffffffff, d);
		axil_write(cpu_alu_pkg::reg_status, 32'hffffffff, resp);
		check_val("bresp", {30'd0, cpu_alu_pkg::resp_slverr}, {30'd0, resp});
		axil_write(12'h020, 32'h1, resp);
		check_val("bresp", {30'd0, cpu_alu_pkg::resp_slverr}, {30'd0, resp});
		axil_read(12'h018, d, resp);
		check_val("rdata", 32'h0, d);
		check_val("rresp", {30'd0, cpu_alu_pkg::resp_slverr}, {30'd0, resp});
		axil_write(cpu_alu_pkg::reg_ra, 32'ha5a55a5a, resp);
		axil_write(cpu_alu_pkg::reg_rb, 32'h01234567, resp);
		axil_read(cpu_alu_pkg::reg_ra, d, resp);
		check_val("ra", 32'ha5a55a5a, d);
		check_val("rresp", {30'd0, cpu_alu_pkg::resp_okay}, {30'd0, resp});
		axil_read(cpu_alu_pkg::reg_rb, d, resp);
		check_val("rb", 32'h01234567, d);

		sva_fails = i_alu_axil_top.i_alu_axil_regs.i_alu_axil_sva.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
